// File: verilog/cmd_defs.svh
/*
 * Sizes and fixed values of the SPI command front end.
 * Included by the command blocks, the SPI target and the testbench.
 */

`ifndef CMD_DEFS_SVH
`define CMD_DEFS_SVH

// Control registers, one byte each
`define CMD_REG_COUNT 4

// Downstream FIFO entries, also the starting credit count
`define CMD_FIFO_DEPTH 8

// Fixed answer to the chip-ID opcode
`define CMD_CHIP_ID 8'h81

// Flops on each SPI pin before edge detection
`define SPI_SYNC_STAGES 2

`endif

// File: verilog/spi_pkg.sv
/*
 * Types for the SPI transport layer.
 * Imported by the SPI target and the testbench.
 */

package spi_pkg;

    // Byte phase inside one select-low frame
    typedef enum logic [1:0] {
        IDLE,    // Deselected
        OPCODE,  // First byte being shifted in
        OPERAND  // Every byte after the opcode
    } spi_phase_e;

endpackage

// File: verilog/cmd_pkg.sv
/*
 * Command set of the front end.
 * Opcodes as sent by the host, and the operation the decoder
 * latches for the rest of the frame.
 */

package cmd_pkg;

    // Opcode byte, first byte of every frame
    typedef enum logic [7:0] {
        REG_WRITE   = 8'h10, // Address then data
        REG_READ    = 8'h11, // Address, data returned in next byte
        STATUS_READ = 8'h12, // Status in first operand byte
        FIFO_WRITE  = 8'h13, // Every operand goes to the FIFO
        CHIP_ID     = 8'hDB  // Fixed ID in first operand byte
    } cmd_opcode_e;

    // Decoded operation, held until select rises
    typedef enum logic [2:0] {
        NONE,
        WRITE_REG,
        READ_REG,
        READ_STATUS,
        PUSH_FIFO,
        READ_ID
    } cmd_op_e;

endpackage

// File: verilog/spi_peripheral.sv
/*
 * SPI mode-0 target, pins oversampled by the system clock.
 * Frames the opcode and operand bytes of each select-low frame and
 * shifts a response byte back for every byte after the opcode.
 */

`timescale 1ns/1ps

`include "cmd_defs.svh"

module spi_peripheral
    import spi_pkg::*, cmd_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        spi_select,
    input  logic        spi_sck,
    input  logic        spi_mosi,
    output logic        spi_miso,
    input  logic [7:0]  response,
    output cmd_opcode_e opcode,
    output logic        opcode_valid,
    output logic [7:0]  operand,
    output logic        operand_valid,
    output logic [7:0]  operand_count,
    output logic        frame_end
);

    localparam int SYNC = `SPI_SYNC_STAGES;

    logic [SYNC-1:0] select_sync;
    logic [SYNC-1:0] sck_sync;
    logic [SYNC-1:0] mosi_sync;
    logic            select_prev;
    logic            sck_prev;
    logic            select_now;
    logic            sck_rise;
    logic            sck_fall;
    logic            select_rise;
    spi_phase_e      phase;
    logic [2:0]      bit_count;
    logic [7:0]      operand_idx;
    logic [7:0]      rx_shift;
    logic [7:0]      rx_next;
    logic [7:0]      tx_shift;

    assign select_now  = select_sync[SYNC-1];
    assign sck_rise    = sck_sync[SYNC-1] & ~sck_prev;
    assign sck_fall    = ~sck_sync[SYNC-1] & sck_prev;
    assign select_rise = select_now & ~select_prev;
    assign rx_next     = {rx_shift[6:0], mosi_sync[SYNC-1]};
    assign spi_miso    = tx_shift[7]; // MSB first

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            select_sync <= '1; // Idle high, no frame
            sck_sync    <= '0;
            mosi_sync   <= '0;
            select_prev <= 1'b1;
            sck_prev    <= 1'b0;
        end else begin
            select_sync <= {select_sync[SYNC-2:0], spi_select};
            sck_sync    <= {sck_sync[SYNC-2:0], spi_sck};
            mosi_sync   <= {mosi_sync[SYNC-2:0], spi_mosi};
            select_prev <= select_now;
            sck_prev    <= sck_sync[SYNC-1];
        end
    end

    // Byte framing and valid pulses
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            phase         <= IDLE;
            bit_count     <= '0;
            operand_idx   <= '0;
            operand_count <= '0;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            frame_end     <= 1'b0;
        end else begin
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            frame_end     <= select_rise;
            if (select_now) begin
                phase       <= IDLE;
                bit_count   <= '0;
                operand_idx <= '0;
            end else begin
                if (phase == IDLE)
                    phase <= OPCODE;
                if (sck_rise) begin
                    bit_count <= bit_count + 3'd1;
                    if (bit_count == 3'd7) begin
                        if (phase == OPERAND) begin
                            operand_valid <= 1'b1;
                            operand_count <= operand_idx;
                            operand_idx   <= operand_idx + 8'd1;
                        end else begin
                            opcode_valid <= 1'b1;
                            phase        <= OPERAND;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sck_rise && !select_now) begin
            rx_shift <= rx_next;
            if (bit_count == 3'd7) begin
                opcode  <= cmd_opcode_e'(rx_next);
                operand <= rx_next;
            end
        end
    end

    // Response goes out on falling edges
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tx_shift <= '0;
        end else if (select_now) begin
            tx_shift <= '0;
        end else if (sck_fall) begin
            if (phase == OPERAND && bit_count == 3'd0)
                tx_shift <= response; // First fall of a new byte
            else
                tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

endmodule

// File: verilog/cmd_decode.sv
/*
 * Command decoder.
 * Latches the operation of the frame, issues register writes and FIFO
 * pushes, and keeps the credits that guard the downstream FIFO.
 */

`timescale 1ns/1ps

`include "cmd_defs.svh"

module cmd_decode
    import cmd_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  cmd_opcode_e opcode,
    input  logic        opcode_valid,
    input  logic [7:0]  operand,
    input  logic        operand_valid,
    input  logic [7:0]  operand_count,
    input  logic        frame_end,
    input  logic        credit_return,
    output cmd_op_e     op,
    output logic        reg_write,
    output logic [1:0]  reg_addr,
    output logic [7:0]  reg_data,
    output logic        fifo_push,
    output logic [7:0]  fifo_wdata,
    output logic [3:0]  credits,
    output logic        overflow
);

    logic fifo_byte;
    logic push_accept;

    assign fifo_byte   = operand_valid && (op == PUSH_FIFO);
    assign push_accept = fifo_byte && (credits != 4'd0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op        <= NONE;
            reg_addr  <= '0;
            reg_write <= 1'b0;
            fifo_push <= 1'b0;
        end else begin
            reg_write <= 1'b0;
            fifo_push <= push_accept;
            if (frame_end) begin
                op <= NONE;
            end else if (opcode_valid) begin
                case (opcode)
                    REG_WRITE:   op <= WRITE_REG;
                    REG_READ:    op <= READ_REG;
                    STATUS_READ: op <= READ_STATUS;
                    FIFO_WRITE:  op <= PUSH_FIFO;
                    CHIP_ID:     op <= READ_ID;
                    default:     op <= NONE; // Unknown opcode
                endcase
            end
            if (operand_valid && (op == WRITE_REG || op == READ_REG) &&
                operand_count == 8'd0)
                reg_addr <= operand[1:0];
            if (operand_valid && op == WRITE_REG && operand_count == 8'd1)
                reg_write <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (operand_valid)
            reg_data <= operand;
        if (push_accept)
            fifo_wdata <= operand;
    end

    // One credit per FIFO slot, spent at the push decision
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credits  <= 4'(`CMD_FIFO_DEPTH);
            overflow <= 1'b0;
        end else begin
            credits <= credits + {3'd0, credit_return} - {3'd0, push_accept};
            if (fifo_byte && credits == 4'd0)
                overflow <= 1'b1; // Host can't stall, byte lost
        end
    end

endmodule

// File: verilog/cmd_execute.sv
/*
 * Control register bank and downstream byte FIFO.
 * Fullness is not checked here since the decoder only pushes with a
 * credit in hand; every pop hands one credit back.
 */

`timescale 1ns/1ps

`include "cmd_defs.svh"

module cmd_execute (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        reg_write,
    input  logic [1:0]  reg_addr,
    input  logic [7:0]  reg_data,
    input  logic        fifo_push,
    input  logic [7:0]  fifo_wdata,
    input  logic        fifo_ready,
    output logic [31:0] control,
    output logic [7:0]  read_data,
    output logic [7:0]  fifo_data,
    output logic        fifo_valid,
    output logic        credit_return
);

    localparam int DEPTH = `CMD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [7:0]   regs [`CMD_REG_COUNT];
    logic [7:0]   mem  [DEPTH];
    logic [PTR_W:0] wr_ptr; // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr;
    logic         pop;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CMD_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (reg_write) begin
            regs[reg_addr] <= reg_data;
        end
    end

    // Register n drives byte n
    for (genvar i = 0; i < `CMD_REG_COUNT; i++) begin : g_control
        assign control[8*i +: 8] = regs[i];
    end

    assign read_data = regs[reg_addr];

    assign fifo_valid = (wr_ptr != rd_ptr);
    assign fifo_data  = mem[rd_ptr[PTR_W-1:0]];
    assign pop        = fifo_valid && fifo_ready;

    always_ff @(posedge clock) begin
        if (fifo_push)
            mem[wr_ptr[PTR_W-1:0]] <= fifo_wdata;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (fifo_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            credit_return <= pop; // Cycle after the pop
        end
    end

endmodule

// File: verilog/cmd_result.sv
/*
 * Response byte for the SPI target.
 * Picks register data, status, chip ID or zero by the decoded
 * operation and registers it.
 */

`timescale 1ns/1ps

`include "cmd_defs.svh"

module cmd_result
    import cmd_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  cmd_op_e    op,
    input  logic [7:0] read_data,
    input  logic [3:0] credits,
    input  logic       overflow,
    output logic [7:0] response
);

    logic [7:0] status;

    // Overflow on top, credits in the low nibble
    assign status = {overflow, 3'b000, credits};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            response <= '0;
        end else begin
            case (op)
                READ_REG:    response <= read_data;
                READ_STATUS: response <= status;
                READ_ID:     response <= `CMD_CHIP_ID;
                default:     response <= 8'h00; // Also unknown opcodes
            endcase
        end
    end

endmodule

// File: verilog/spi_cmd_top.sv
/*
 * Top level of the SPI command front end.
 * SPI target feeding decode, execute and result on one system clock.
 */

`timescale 1ns/1ps

module spi_cmd_top
    import cmd_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        spi_select,
    input  logic        spi_sck,
    input  logic        spi_mosi,
    output logic        spi_miso,
    output logic [31:0] control,
    output logic [7:0]  fifo_data,
    output logic        fifo_valid,
    input  logic        fifo_ready
);

    cmd_opcode_e opcode;
    logic        opcode_valid;
    logic [7:0]  operand;
    logic        operand_valid;
    logic [7:0]  operand_count;
    logic        frame_end;
    logic [7:0]  response;

    cmd_op_e     op;
    logic        reg_write;
    logic [1:0]  reg_addr;
    logic [7:0]  reg_data;
    logic        fifo_push;
    logic [7:0]  fifo_wdata;
    logic [3:0]  credits;
    logic        overflow;
    logic        credit_return;
    logic [7:0]  read_data;

    spi_peripheral u_spi (
        .clock         (clock),
        .arst_n        (arst_n),
        .spi_select    (spi_select),
        .spi_sck       (spi_sck),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .response      (response),
        .opcode        (opcode),
        .opcode_valid  (opcode_valid),
        .operand       (operand),
        .operand_valid (operand_valid),
        .operand_count (operand_count),
        .frame_end     (frame_end)
    );

    cmd_decode u_decode (
        .clock         (clock),
        .arst_n        (arst_n),
        .opcode        (opcode),
        .opcode_valid  (opcode_valid),
        .operand       (operand),
        .operand_valid (operand_valid),
        .operand_count (operand_count),
        .frame_end     (frame_end),
        .credit_return (credit_return),
        .op            (op),
        .reg_write     (reg_write),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .fifo_push     (fifo_push),
        .fifo_wdata    (fifo_wdata),
        .credits       (credits),
        .overflow      (overflow)
    );

    cmd_execute u_execute (
        .clock         (clock),
        .arst_n        (arst_n),
        .reg_write     (reg_write),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .fifo_push     (fifo_push),
        .fifo_wdata    (fifo_wdata),
        .fifo_ready    (fifo_ready),
        .control       (control),
        .read_data     (read_data),
        .fifo_data     (fifo_data),
        .fifo_valid    (fifo_valid),
        .credit_return (credit_return)
    );

    cmd_result u_result (
        .clock     (clock),
        .arst_n    (arst_n),
        .op        (op),
        .read_data (read_data),
        .credits   (credits),
        .overflow  (overflow),
        .response  (response)
    );

endmodule

// File: sim/spi_cmd_assert.sv
/*
 * Concurrent checks on the FIFO credits and the FIFO reset state.
 * Bound into the decoder and the execute block below.
 */

`timescale 1ns/1ps

`include "cmd_defs.svh"

module spi_cmd_assert
    import cmd_pkg::*;
(
    input logic       clock,
    input logic       arst_n,
    input logic       push,
    input logic [3:0] credits,
    input logic       valid
);

    // Push was granted with a credit in hand
    assert property (@(posedge clock) disable iff (!arst_n)
        push |-> $past(credits) != 4'd0)
        else $error("push issued with zero credits");

    assert property (@(posedge clock) disable iff (!arst_n)
        credits <= 4'(`CMD_FIFO_DEPTH))
        else $error("credit count above FIFO depth");

    assert property (@(posedge clock) $rose(arst_n) |-> !valid)
        else $error("fifo_valid high right after reset");

endmodule

bind cmd_decode spi_cmd_assert u_decode_assert (
    .clock   (clock),
    .arst_n  (arst_n),
    .push    (fifo_push),
    .credits (credits),
    .valid   (1'b0)
);

// Free FIFO slots stand in for credits on the execute side
bind cmd_execute spi_cmd_assert u_execute_assert (
    .clock   (clock),
    .arst_n  (arst_n),
    .push    (fifo_push),
    .credits (4'(`CMD_FIFO_DEPTH) - (wr_ptr - rd_ptr)),
    .valid   (fifo_valid)
);

// File: sim/spi_cmd_tb.sv
/*
 * Testbench for the SPI command front end.
 * Bit-bangs SPI frames from a table, models the control registers
 * and the downstream FIFO, and checks every response byte.
 */

`timescale 1ns/1ps

`include "cmd_defs.svh"

module spi_cmd_tb
    import spi_pkg::*, cmd_pkg::*;
;

    localparam int    TABLE_LEN  = 11;
    localparam int    HALF_CLKS  = 4;                 // 80 ns SCK half-period
    localparam int    FRAME_CLKS = 11 * 16 * HALF_CLKS + 16;
    localparam int    DRAIN_CLKS = 200;               // Longest wait for an empty FIFO
    localparam longint WATCHDOG_NS = (TABLE_LEN + 14) * FRAME_CLKS * 2 * 20 + 20000;

    typedef struct {
        string           name;
        logic [7:0]      opc;
        logic [3:0][7:0] ops;
        int              n;
        logic [3:0][7:0] exp;
        logic [3:0]      mask;  // Which response bytes are checked
    } test_t;

    logic        clock;
    logic        arst_n;
    logic        spi_select;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic [31:0] control;
    logic [7:0]  fifo_data;
    logic        fifo_valid;
    logic        fifo_ready;

    test_t      tests [TABLE_LEN];
    logic [7:0] model [`CMD_REG_COUNT];
    logic [7:0] tx_buf [16];
    logic [7:0] rx_buf [16];
    logic [7:0] expected_q [$];
    int         ready_mode;    // 0 low, 1 high, 2 random
    int         pushed_count;
    int         popped_count;

    spi_cmd_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Consumer side, driven just after the edge
    always @(posedge clock) begin
        #2;
        case (ready_mode)
            0:       fifo_ready = 1'b0;
            1:       fifo_ready = 1'b1;
            default: fifo_ready = 1'($urandom % 2);
        endcase
    end

    // Transfer happens on the next rising edge
    always @(negedge clock) begin
        if (arst_n && fifo_valid && fifo_ready) begin
            if (expected_q.size() == 0)
                fail_run("A byte left the FIFO that was never accepted");
            check_fifo_byte("fifo_stream", expected_q.pop_front(), fifo_data);
            popped_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("Timeout: the run did not finish in the expected time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_response(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
        if (act !== exp)
            fail_run($sformatf("FAILED %s response expected %h actual %h", name, exp, act));
    endtask

    task automatic check_control(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp)
            fail_run($sformatf("FAILED %s control expected %h actual %h", name, exp, act));
    endtask

    task automatic check_fifo_byte(input string name, input logic [7:0] exp,
                                   input logic [7:0] act);
        if (act !== exp)
            fail_run($sformatf("FAILED %s fifo byte expected %h actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input logic exp_ovf,
                                input logic [3:0] exp_credits, input logic [7:0] act);
        if (act[7] !== exp_ovf || act[3:0] !== exp_credits || act[6:4] !== 3'b000)
            fail_run($sformatf("FAILED %s status expected ovf %b credits %0d actual %h",
                               name, exp_ovf, exp_credits, act));
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock);
        #2;
    endtask

    // Mode 0: MOSI set while SCK low, MISO taken just before the rise
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            wait_clocks(HALF_CLKS);
            rx[i] = spi_miso;
            spi_sck = 1'b1;
            wait_clocks(HALF_CLKS);
            spi_sck = 1'b0;
        end
    endtask

    // Opcode then n operands from tx_buf, responses into rx_buf
    task automatic spi_frame(input logic [7:0] opc, input int n);
        logic [7:0] unused;
        spi_select = 1'b0;
        wait_clocks(HALF_CLKS);
        spi_byte(opc, unused);
        for (int i = 0; i < n; i++)
            spi_byte(tx_buf[i], rx_buf[i]);
        wait_clocks(HALF_CLKS);
        spi_select = 1'b1;
        wait_clocks(8);
    endtask

    task automatic read_status(output logic [7:0] status);
        tx_buf[0] = 8'h00;
        spi_frame(8'h12, 1);
        status = rx_buf[0];
    endtask

    // Until the DUT shows an empty FIFO
    task automatic wait_drain(input string name);
        int waited;
        waited = 0;
        while (fifo_valid) begin
            if (waited == DRAIN_CLKS)
                fail_run($sformatf("%s: the FIFO never emptied", name));
            wait_clocks(1);
            waited++;
        end
        wait_clocks(4); // Credits come back two cycles after a pop
    endtask

    task automatic confirm_all_delivered(input string name);
        if (expected_q.size() != 0)
            fail_run($sformatf("FAILED %s bytes left expected 0 actual %0d",
                               name, expected_q.size()));
    endtask

    function automatic test_t make_test(input string name, input logic [7:0] opc,
                                        input int n, input logic [7:0] o0,
                                        input logic [7:0] o1, input logic [7:0] e0,
                                        input logic [7:0] e1, input logic [3:0] mask);
        test_t t;
        t.name = name;
        t.opc  = opc;
        t.ops  = {8'h00, 8'h00, o1, o0};
        t.n    = n;
        t.exp  = {8'h00, 8'h00, e1, e0};
        t.mask = mask;
        return t;
    endfunction

    initial begin
        logic [7:0] status;
        logic [7:0] exp;
        int         n;

        void'($urandom(35));
        arst_n       = 1'b0;
        spi_select   = 1'b1;
        spi_sck      = 1'b0;
        spi_mosi     = 1'b0;
        fifo_ready   = 1'b0;
        ready_mode   = 1;
        pushed_count = 0;
        popped_count = 0;
        for (int i = 0; i < `CMD_REG_COUNT; i++)
            model[i] = 8'h00;

        tests[0]  = make_test("chip_id",    8'hDB, 1, 8'h00, 8'h00, 8'h81, 8'h00, 4'b0001);
        tests[1]  = make_test("unknown_op", 8'h55, 1, 8'h00, 8'h00, 8'h00, 8'h00, 4'b0001);
        tests[2]  = make_test("write_r0",   8'h10, 2, 8'h04, 8'hA5, 8'h00, 8'h00, 4'b0011);
        tests[3]  = make_test("write_r1",   8'h10, 2, 8'h01, 8'h3C, 8'h00, 8'h00, 4'b0011);
        tests[4]  = make_test("write_r2",   8'h10, 2, 8'h0E, 8'h7F, 8'h00, 8'h00, 4'b0011);
        tests[5]  = make_test("write_r3",   8'h10, 2, 8'hFB, 8'hC2, 8'h00, 8'h00, 4'b0011);
        tests[6]  = make_test("read_r0",    8'h11, 2, 8'h08, 8'h00, 8'h00, 8'h00, 4'b0010);
        tests[7]  = make_test("read_r1",    8'h11, 2, 8'h01, 8'h00, 8'h00, 8'h00, 4'b0010);
        tests[8]  = make_test("read_r2",    8'h11, 2, 8'h02, 8'h00, 8'h00, 8'h00, 4'b0010);
        tests[9]  = make_test("read_r3",    8'h11, 2, 8'h07, 8'h00, 8'h00, 8'h00, 4'b0010);
        tests[10] = make_test("status_idle", 8'h12, 1, 8'h00, 8'h00, 8'h08, 8'h00, 4'b0001);

        wait_clocks(5);
        arst_n = 1'b1;
        wait_clocks(4);

        for (int t = 0; t < TABLE_LEN; t++) begin
            for (int i = 0; i < tests[t].n; i++)
                tx_buf[i] = tests[t].ops[i];
            spi_frame(tests[t].opc, tests[t].n);
            for (int i = 0; i < tests[t].n; i++) begin
                exp = tests[t].exp[i];
                if (tests[t].opc == 8'h11 && i == 1)
                    exp = model[tests[t].ops[0][1:0]]; // Data follows the address
                if (tests[t].mask[i])
                    check_response(tests[t].name, exp, rx_buf[i]);
            end
            if (tests[t].opc == 8'h10) begin
                model[tests[t].ops[0][1:0]] = tests[t].ops[1];
                check_control(tests[t].name, {model[3], model[2], model[1], model[0]},
                              control);
            end
        end

        // In-order stream with the consumer always ready
        for (int i = 0; i < 6; i++) begin
            tx_buf[i] = 8'($urandom);
            expected_q.push_back(tx_buf[i]);
        end
        spi_frame(8'h13, 6);
        wait_drain("fifo_order");
        confirm_all_delivered("fifo_order");
        read_status(status);
        check_status("fifo_order", 1'b0, 4'd8, status);

        // Stalled consumer, last two bytes have no credit
        ready_mode = 0;
        wait_clocks(2);
        for (int i = 0; i < 10; i++) begin
            tx_buf[i] = 8'($urandom);
            if (i < `CMD_FIFO_DEPTH)
                expected_q.push_back(tx_buf[i]);
        end
        spi_frame(8'h13, 10);
        read_status(status);
        check_status("backpressure_full", 1'b1, 4'd0, status);
        if (fifo_valid !== 1'b1)
            fail_run("The FIFO shows no data while the consumer is stalled");
        check_fifo_byte("backpressure_head", expected_q[0], fifo_data);
        ready_mode = 1;
        wait_drain("backpressure_drained");
        confirm_all_delivered("backpressure_drained");
        read_status(status);
        check_status("backpressure_drained", 1'b1, 4'd8, status);

        // Random consumer pattern
        ready_mode = 2;
        pushed_count = 0;
        popped_count = 0;
        for (int f = 0; f < 8; f++) begin
            n = 1 + int'($urandom % 6);
            for (int i = 0; i < n; i++) begin
                tx_buf[i] = 8'($urandom);
                expected_q.push_back(tx_buf[i]);
            end
            pushed_count += n;
            spi_frame(8'h13, n);
        end
        wait_drain("random_traffic");
        if (popped_count != pushed_count)
            fail_run($sformatf("FAILED random_traffic count expected %0d actual %0d",
                               pushed_count, popped_count));
        ready_mode = 1;
        read_status(status);
        check_status("random_traffic", 1'b1, 4'd8, status);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/spi_pkg.sv
verilog/cmd_pkg.sv
verilog/spi_peripheral.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/cmd_result.sv
verilog/spi_cmd_top.sv
sim/spi_cmd_assert.sv
sim/spi_cmd_tb.sv

// File: Makefile
# Verilator build and run of the SPI command front end

VERILATOR  ?= verilator
TOP        ?= spi_cmd_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
